// File: build.f
src/debug_pkg.sv
src/uart_rx.sv
src/dump_sequencer.sv
src/word_serializer.sv
src/uart_tx.sv
src/debug_unit_top.sv
test/tb_clock.sv
test/tb_debug_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_debug_unit \
    -f build.f -o tb_debug_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_debug_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if echo "$output" | grep -qxF "Simulation completed successfully"; then
    exit 0
fi
exit 1

// File: test/tb_debug_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_debug_unit
    import debug_pkg::*;
;

    localparam int DUMP_WORDS = 74;
    // Frame plus the start and done hand-off cycles around it
    localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT + 2;
    localparam int DUMP_CYCLES = 4 * DUMP_WORDS * BYTE_CYCLES + 3 * DUMP_WORDS;
    localparam int WATCHDOG_CYCLES = 3 * DUMP_CYCLES + 2000;

    logic        clk;
    logic        rst;
    logic        rxd;
    logic [31:0] pc;
    logic [31:0] reg_data;
    logic [31:0] mem_data;
    logic [31:0] latch_data;
    logic        txd;
    logic [31:0] debug_addr;
    latch_sel_t  latch_sel;
    logic        debug_on;
    logic        cpu_halt;

    logic [31:0] expect_q[$];
    logic [31:0] seed;
    int          errors;
    int          dump_words;
    int          frames_seen;
    int          tests_passed;
    int          tests_failed;
    int          latch_counts[5] = '{2, 6, 6, 5, 2};

    tb_clock u_clock (.clk(clk));

    debug_unit_top UUT (
        .clk        (clk),
        .rst        (rst),
        .rxd        (rxd),
        .pc         (pc),
        .reg_data   (reg_data),
        .mem_data   (mem_data),
        .latch_data (latch_data),
        .txd        (txd),
        .debug_addr (debug_addr),
        .latch_sel  (latch_sel),
        .debug_on   (debug_on),
        .cpu_halt   (cpu_halt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] latch_word(input logic [2:0] stage, input logic [3:0] idx);
        return 32'h3000_0000 | {21'd0, stage, 4'd0, idx};
    endfunction

    ////////////////////////////////////////
    // Processor data model
    ////////////////////////////////////////

    assign reg_data   = lcg_next(debug_addr) ^ 32'h1000_0000;
    assign mem_data   = lcg_next(debug_addr) ^ 32'h2000_0000;
    assign latch_data = latch_word(latch_sel.stage, latch_sel.signal_idx);

    // Serial line only moves during a dump
    assert property (@(posedge clk) disable iff (rst) !txd |-> (debug_on && cpu_halt))
    else
    begin
        $display("txd went low while no dump was running at %0t", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst) cpu_halt == debug_on)
    else
    begin
        $display("cpu_halt and debug_on disagree at %0t", $time);
        errors++;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            rxd = frame[i];
            wait_cycles(CLKS_PER_BIT);
        end
    endtask

    task automatic build_expected(input logic [31:0] pc_val);
        expect_q.delete();
        expect_q.push_back(pc_val);
        for (int r = 0; r < 32; r++)
            expect_q.push_back(lcg_next(32'(r)) ^ 32'h1000_0000);
        for (int m = 0; m < 20; m++)
            expect_q.push_back(lcg_next(32'(m)) ^ 32'h2000_0000);
        for (int s = 0; s < 5; s++)
            for (int k = 0; k < latch_counts[s]; k++)
                expect_q.push_back(latch_word(3'(s), 4'(k)));
    endtask

    ////////////////////////////////////////
    // Monitor samples txd mid-bit on negedge
    ////////////////////////////////////////

    task automatic receive_byte(output logic [7:0] b);
        @(negedge txd);
        frames_seen++;
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (txd)
        else
        begin
            $display("Missing stop bit on txd at %0t", $time);
            errors++;
        end
    endtask

    initial
    begin : tx_monitor
        logic [7:0]  b;
        logic [31:0] w;
        logic [31:0] exp_w;
        forever
        begin
            // LSB first
            for (int k = 0; k < 4; k++)
            begin
                receive_byte(b);
                w[8*k +: 8] = b;
            end
            if (expect_q.size() == 0)
            begin
                $display("Unexpected extra word on txd at %0t", $time);
                errors++;
            end
            else
            begin
                exp_w = expect_q.pop_front();
                assert (w == exp_w)
                else
                begin
                    $display("[ERROR] txd word %0d: got 0x%08h, expected 0x%08h",
                             dump_words, w, exp_w);
                    errors++;
                end
            end
            dump_words++;
        end
    end

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            assert (txd && !debug_on && !cpu_halt)
            else
            begin
                $display("Unit left idle without a dump command at %0t", $time);
                errors++;
            end
        end
        wait_cycles(1);
    endtask

    // A nonzero resend_after resends the command once that many words are out
    task automatic run_dump(input int resend_after);
        int frames_before;
        seed = lcg_next(seed);
        pc   = seed;
        build_expected(seed);
        dump_words    = 0;
        frames_before = frames_seen;
        send_byte(DUMP_CMD);
        wait (debug_on === 1'b1);
        assert (frames_seen == frames_before)
        else
        begin
            $display("A txd frame started before debug_on rose");
            errors++;
        end
        if (resend_after > 0)
        begin
            wait (dump_words >= resend_after);
            wait_cycles(1);
            send_byte(DUMP_CMD);
        end
        wait (debug_on === 1'b0);
        assert (dump_words == DUMP_WORDS)
        else
        begin
            $display("[ERROR] dump word count: got 0x%0h, expected 0x%0h",
                     dump_words, DUMP_WORDS);
            errors++;
        end
        wait_cycles(1);
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark)
        begin
            tests_passed++;
            $display("PASS  %s", name);
        end
        else
        begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - mark);
        end
    endtask

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin : main
        int mark;
        rst          = 1'b1;
        rxd          = 1'b1;
        pc           = '0;
        seed         = 32'h6ffb;
        errors       = 0;
        dump_words   = 0;
        frames_seen  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        mark = errors;
        check_idle(20 * CLKS_PER_BIT);
        finish_test("idle after reset", mark);

        mark = errors;
        send_byte(8'h55);
        check_idle(20 * CLKS_PER_BIT);
        finish_test("non-command byte ignored", mark);

        mark = errors;
        run_dump(0);
        finish_test("full dump order and halt window", mark);

        mark = errors;
        run_dump(10);
        run_dump(0);
        check_idle(20 * CLKS_PER_BIT);
        finish_test("command during dump, then repeat dump", mark);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock
(
    output logic clk
);

    // 100 ns period
    initial clk = 1'b0;

    always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: src/debug_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module debug_unit_top
    import debug_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rxd,
    input  logic [31:0] pc,
    input  logic [31:0] reg_data,
    input  logic [31:0] mem_data,
    input  logic [31:0] latch_data,
    output logic        txd,
    output logic [31:0] debug_addr,
    output latch_sel_t  latch_sel,
    output logic        debug_on,
    output logic        cpu_halt
);

    rx_byte_t   rx;
    dump_item_t item;
    logic       word_start;
    logic       word_done;
    logic [7:0] tx_byte;
    logic       byte_start;
    logic       byte_done;

    ////////////////////////////////////////
    // Receive, sequence, serialize, send
    ////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk (clk),
        .rst (rst),
        .rxd (rxd),
        .rx  (rx)
    );

    dump_sequencer u_dump_sequencer (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .pc         (pc),
        .reg_data   (reg_data),
        .mem_data   (mem_data),
        .latch_data (latch_data),
        .word_done  (word_done),
        .debug_addr (debug_addr),
        .latch_sel  (latch_sel),
        .debug_on   (debug_on),
        .cpu_halt   (cpu_halt),
        .item       (item),
        .word_start (word_start)
    );

    word_serializer u_word_serializer (
        .clk        (clk),
        .rst        (rst),
        .item       (item),
        .word_start (word_start),
        .byte_done  (byte_done),
        .tx_byte    (tx_byte),
        .byte_start (byte_start),
        .word_done  (word_done)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .tx_byte    (tx_byte),
        .byte_start (byte_start),
        .txd        (txd),
        .byte_done  (byte_done)
    );

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       byte_start,
    output logic       txd,
    output logic       byte_done
);

    logic [FRAME_BITS-1:0] frame_q;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [3:0]            bit_idx;
    logic                  busy;
    logic                  done_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // All ones keeps the line idle high
            frame_q <= '1;
            bit_cnt <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!busy)
            begin
                if (byte_start)
                begin
                    // Stop bit on top, start bit goes out first
                    frame_q <= {1'b1, tx_byte, 1'b0};
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    busy    <= 1'b1;
                end
            end
            else if (bit_cnt == BIT_LAST)
            begin
                bit_cnt <= '0;
                frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
                if (bit_idx == FRAME_LAST)
                begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
                else
                    bit_idx <= bit_idx + 4'd1;
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign txd       = frame_q[0];
    assign byte_done = done_q;

endmodule

`default_nettype wire

// File: src/word_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module word_serializer
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dump_item_t item,
    input  logic       word_start,
    input  logic       byte_done,
    output logic [7:0] tx_byte,
    output logic       byte_start,
    output logic       word_done
);

    dump_word_u word_q;
    logic [1:0] byte_idx;
    logic       active;
    logic       start_q;
    logic       done_q;

    always_ff @(posedge clk)
    begin
        if (word_start)
            word_q <= item.data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            byte_idx <= '0;
            active   <= 1'b0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
            if (word_start)
            begin
                active   <= 1'b1;
                byte_idx <= '0;
                start_q  <= 1'b1;
            end
            else if (active && byte_done)
            begin
                if (byte_idx == 2'd3)
                begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
                else
                begin
                    byte_idx <= byte_idx + 2'd1;
                    start_q  <= 1'b1;
                end
            end
        end
    end

    // Byte 0 is the least significant
    assign tx_byte    = word_q.bytes[byte_idx];
    assign byte_start = start_q;
    assign word_done  = done_q;

endmodule

`default_nettype wire

// File: src/dump_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module dump_sequencer
    import debug_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  rx_byte_t    rx,
    input  logic [31:0] pc,
    input  logic [31:0] reg_data,
    input  logic [31:0] mem_data,
    input  logic [31:0] latch_data,
    input  logic        word_done,
    output logic [31:0] debug_addr,
    output latch_sel_t  latch_sel,
    output logic        debug_on,
    output logic        cpu_halt,
    output dump_item_t  item,
    output logic        word_start
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND_PC,
        S_SEND_REG,
        S_SEND_MEM,
        S_SEND_LATCH,
        S_WAIT_WORD
    } seq_state_t;

    seq_state_t state;
    seq_state_t ret_state;
    logic       active;
    logic       start_q;
    logic       last_signal;
    logic       last_stage;

    assign last_signal = latch_sel.signal_idx == LATCH_SIGNALS[latch_sel.stage] - 4'd1;
    assign last_stage  = latch_sel.stage == STAGE_LAST;

    ////////////////////////////////////////
    // Dump FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            ret_state  <= S_IDLE;
            active     <= 1'b0;
            start_q    <= 1'b0;
            debug_addr <= '0;
            latch_sel  <= '0;
            item       <= '0;
        end
        else
        begin
            start_q <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    // Other bytes are not commands
                    if (rx.valid && rx.data == DUMP_CMD)
                    begin
                        active     <= 1'b1;
                        debug_addr <= '0;
                        latch_sel  <= '0;
                        state      <= S_SEND_PC;
                    end
                end
                S_SEND_PC:
                begin
                    item.data.word <= pc;
                    item.last      <= 1'b0;
                    start_q        <= 1'b1;
                    ret_state      <= S_SEND_REG;
                    state          <= S_WAIT_WORD;
                end
                S_SEND_REG:
                begin
                    item.data.word <= reg_data;
                    start_q        <= 1'b1;
                    state          <= S_WAIT_WORD;
                    if (debug_addr == REG_LAST)
                    begin
                        debug_addr <= '0;
                        ret_state  <= S_SEND_MEM;
                    end
                    else
                    begin
                        debug_addr <= debug_addr + 32'd1;
                        ret_state  <= S_SEND_REG;
                    end
                end
                S_SEND_MEM:
                begin
                    item.data.word <= mem_data;
                    start_q        <= 1'b1;
                    state          <= S_WAIT_WORD;
                    if (debug_addr == MEM_LAST)
                    begin
                        debug_addr <= '0;
                        ret_state  <= S_SEND_LATCH;
                    end
                    else
                    begin
                        debug_addr <= debug_addr + 32'd1;
                        ret_state  <= S_SEND_MEM;
                    end
                end
                S_SEND_LATCH:
                begin
                    item.data.word <= latch_data;
                    start_q        <= 1'b1;
                    state          <= S_WAIT_WORD;
                    ret_state      <= S_SEND_LATCH;
                    if (last_signal)
                    begin
                        latch_sel.signal_idx <= '0;
                        if (last_stage)
                        begin
                            // Final write-back signal closes the dump
                            latch_sel.stage <= '0;
                            item.last       <= 1'b1;
                            ret_state       <= S_IDLE;
                        end
                        else
                            latch_sel.stage <= latch_sel.stage + 3'd1;
                    end
                    else
                        latch_sel.signal_idx <= latch_sel.signal_idx + 4'd1;
                end
                S_WAIT_WORD:
                begin
                    if (word_done)
                    begin
                        state <= ret_state;
                        if (item.last)
                            active <= 1'b0;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Processor stays frozen for the whole dump
    assign debug_on   = active;
    assign cpu_halt   = active;
    assign word_start = start_q;

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
    import debug_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rxd,
    output rx_byte_t rx
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic [1:0]           sync_q;
    logic                 rxd_prev;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift_q;
    logic                 valid_q;

    // Host line is asynchronous to clk
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sync_q   <= 2'b11;
            rxd_prev <= 1'b1;
        end
        else
        begin
            sync_q   <= {sync_q[0], rxd};
            rxd_prev <= sync_q[1];
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    bit_cnt <= '0;
                    // Falling edge opens a frame
                    if (rxd_prev && !sync_q[1])
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (bit_cnt == HALF_LAST)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // High again at mid start bit, treat as a glitch
                        state   <= sync_q[1] ? RX_IDLE : RX_DATA;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    if (bit_cnt == BIT_LAST)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_STOP:
                begin
                    if (bit_cnt == BIT_LAST)
                    begin
                        // Framing error drops the byte
                        valid_q <= sync_q[1];
                        state   <= RX_IDLE;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && bit_cnt == BIT_LAST)
            shift_q <= {sync_q[1], shift_q[7:1]};
    end

    assign rx.data  = shift_q;
    assign rx.valid = valid_q;

endmodule

`default_nettype wire

// File: src/debug_pkg.sv
`default_nettype none

package debug_pkg;

    ////////////////////////////////////////
    // Serial link
    ////////////////////////////////////////

    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
    // Middle of the start bit
    localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // Start, 8 data, stop
    localparam int FRAME_BITS = 10;
    localparam logic [3:0] FRAME_LAST = 4'(FRAME_BITS - 1);

    localparam logic [7:0] DUMP_CMD = 8'h44;

    ////////////////////////////////////////
    // Dump layout
    ////////////////////////////////////////

    localparam int REG_COUNT = 32;
    localparam int MEM_WORDS = 20;
    localparam int LATCH_STAGES = 5;
    localparam logic [31:0] REG_LAST = 32'(REG_COUNT - 1);
    localparam logic [31:0] MEM_LAST = 32'(MEM_WORDS - 1);
    localparam logic [2:0] STAGE_LAST = 3'(LATCH_STAGES - 1);

    // Fetch, decode, execute, memory, write-back
    localparam logic [3:0] LATCH_SIGNALS [LATCH_STAGES] = '{4'd2, 4'd6, 4'd6, 4'd5, 4'd2};

    typedef struct packed {
        logic [2:0] stage;
        logic [3:0] signal_idx;
    } latch_sel_t;

    // Written as a full word, read back byte by byte
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } dump_word_u;

    typedef struct packed {
        dump_word_u data;
        logic       last;
    } dump_item_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } rx_byte_t;

endpackage

`default_nettype wire
